// ==== calc_input.txt ====
# W slot row col value | D slot m n | C test op id_a id_b scalar err m n | R test row col value
# value and scalar in hex, other fields decimal; op 0 tr, 1 add, 2 sub, 3 mul, 4 scalar
D 0 3 3  D 1 3 3  D 2 2 4
W 0 0 0 1  W 0 0 1 2  W 0 0 2 3
W 0 1 0 4  W 0 1 1 5  W 0 1 2 6
W 0 2 0 80000000  W 0 2 1 8  W 0 2 2 9
W 1 0 0 7  W 1 0 1 1  W 1 0 2 9
W 1 1 0 2  W 1 1 1 8  W 1 1 2 3
W 1 2 0 1  W 1 2 1 fffffffe  W 1 2 2 4
W 2 0 0 11  W 2 0 1 12  W 2 0 2 13  W 2 0 3 14
W 2 1 0 21  W 2 1 1 22  W 2 1 2 23  W 2 1 3 24
C add 1 0 1 0 0 3 3
R add 0 0 8  R add 0 1 3  R add 0 2 c
R add 1 0 6  R add 1 1 d  R add 1 2 9
R add 2 0 80000001  R add 2 1 6  R add 2 2 d
C sub 2 0 1 0 0 3 3
R sub 0 0 fffffffa  R sub 0 1 1  R sub 0 2 fffffffa
R sub 1 0 2  R sub 1 1 fffffffd  R sub 1 2 3
R sub 2 0 7fffffff  R sub 2 1 a  R sub 2 2 5
C trans 0 2 2 0 0 4 2
R trans 0 0 11  R trans 0 1 21  R trans 1 0 12  R trans 1 1 22
R trans 2 0 13  R trans 2 1 23  R trans 3 0 14  R trans 3 1 24
D 0 2 3  D 1 3 2
C mul 3 0 1 0 0 2 2
R mul 0 0 e  R mul 0 1 b  R mul 1 0 2c  R mul 1 1 20
D 2 5 5
W 2 0 0 1  W 2 0 1 2  W 2 0 2 3  W 2 0 3 4  W 2 0 4 5
W 2 1 0 6  W 2 1 1 7  W 2 1 2 8  W 2 1 3 9  W 2 1 4 a
W 2 2 0 b  W 2 2 1 c  W 2 2 2 d  W 2 2 3 e  W 2 2 4 f
W 2 3 0 10  W 2 3 1 11  W 2 3 2 12  W 2 3 3 13  W 2 3 4 14
W 2 4 0 15  W 2 4 1 16  W 2 4 2 fffffffe  W 2 4 3 40000000  W 2 4 4 19
C scl 4 2 2 fffffffd 0 5 5
R scl 0 0 fffffffd  R scl 0 1 fffffffa  R scl 0 2 fffffff7  R scl 0 3 fffffff4
R scl 0 4 fffffff1  R scl 1 0 ffffffee  R scl 1 1 ffffffeb  R scl 1 2 ffffffe8
R scl 1 3 ffffffe5  R scl 1 4 ffffffe2  R scl 2 0 ffffffdf  R scl 2 1 ffffffdc
R scl 2 2 ffffffd9  R scl 2 3 ffffffd6  R scl 2 4 ffffffd3  R scl 3 0 ffffffd0
R scl 3 1 ffffffcd  R scl 3 2 ffffffca  R scl 3 3 ffffffc7  R scl 3 4 ffffffc4
R scl 4 0 ffffffc1  R scl 4 1 ffffffbe  R scl 4 2 6  R scl 4 3 40000000  R scl 4 4 ffffffb5
C bad_add 1 0 1 0 1 5 5
C bad_mul 3 0 0 0 1 5 5
R bad_mul 0 0 fffffffd  R bad_mul 2 2 ffffffd9  R bad_mul 4 3 40000000  R bad_mul 4 4 ffffffb5

// ==== project.f ====
calc_pkg.sv
matrix_store.sv
compute_ctrl.sv
matrix_alu.sv
matrix_calc_top.sv
tb_matrix_calc.sv

// ==== Makefile ====
# Verilator build and run for the matrix calculator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= tb_matrix_calc
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_matrix_calc.sv ====
/*
 * matrix calculator testbench
 * replays calc_input.txt: element and dimension loads, computes with
 * expected error bit and result size, and result slot readback
 */
module tb_matrix_calc;

    logic              clk;
    logic              sys_rst;
    logic              wr_en;
    logic              dim_we;
    calc_pkg::slot_t   wr_slot;
    calc_pkg::idx_t    wr_row;
    calc_pkg::idx_t    wr_col;
    calc_pkg::elem_t   wr_data;
    calc_pkg::dim_t    dim_m;
    calc_pkg::dim_t    dim_n;
    logic              start;
    calc_pkg::alu_op_e op;
    calc_pkg::slot_t   id_a;
    calc_pkg::slot_t   id_b;
    calc_pkg::elem_t   scalar;
    calc_pkg::idx_t    rd_row;
    calc_pkg::idx_t    rd_col;
    calc_pkg::elem_t   rd_data;
    calc_pkg::dim_t    res_m;
    calc_pkg::dim_t    res_n;
    logic              busy;
    logic              done;
    logic              error;

    int mismatches;  // wrong values
    int failures;    // timeouts, file trouble
    int checks;

    matrix_calc_top matrix_calc_top_inst (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;  // period 100

    // ==============================
    // helpers
    // ==============================
    task automatic check_value(input logic [8*16-1:0] test, input string what,
                               input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("FAIL %0s %0s: expected %0d, actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic write_elem(input int slot, input int row, input int col,
                              input logic [31:0] val);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_slot <= calc_pkg::slot_t'(slot);
        wr_row  <= calc_pkg::idx_t'(row);
        wr_col  <= calc_pkg::idx_t'(col);
        wr_data <= val;
        @(posedge clk);  // store takes it here
        wr_en   <= 1'b0;
    endtask

    task automatic set_dims(input int slot, input int m, input int n);
        @(posedge clk);
        dim_we  <= 1'b1;
        wr_slot <= calc_pkg::slot_t'(slot);
        dim_m   <= calc_pkg::dim_t'(m);
        dim_n   <= calc_pkg::dim_t'(n);
        @(posedge clk);
        dim_we  <= 1'b0;
    endtask

    // no back-pressure, so never start into a busy DUT
    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            failures++;
            $display("timeout: DUT still busy %0d cycles before a start", limit);
        end
    endtask

    task automatic run_compute(input logic [8*16-1:0] test, input int opc,
                               input int a, input int b, input logic [31:0] scl,
                               input int exp_err, input int exp_m, input int exp_n);
        int n;
        wait_idle(50);
        @(posedge clk);
        start  <= 1'b1;  // one cycle pulse
        op     <= calc_pkg::alu_op_e'(opc);
        id_a   <= calc_pkg::slot_t'(a);
        id_b   <= calc_pkg::slot_t'(b);
        scalar <= scl;
        @(posedge clk);
        start  <= 1'b0;
        n = 0;
        @(negedge clk);
        check_value(test, "busy at start", 1, 32'(busy));  // cycle after start
        while (!done && n < 200) begin  // 5x5 worst case well inside
            @(negedge clk);
            n++;
        end
        if (!done) begin
            failures++;
            $display("timeout: no done pulse for %0s within 200 cycles", test);
        end else begin
            check_value(test, "error", exp_err, 32'(error));
            @(negedge clk);  // result dims written on the done edge
            check_value(test, "done pulse", 0, 32'(done));
            check_value(test, "res_m", exp_m, 32'(res_m));
            check_value(test, "res_n", exp_n, 32'(res_n));
            check_value(test, "error held", exp_err, 32'(error));
            check_value(test, "busy", 0, 32'(busy));
        end
    endtask

    task automatic read_result(input logic [8*16-1:0] test, input int row, input int col,
                               input logic [31:0] expected);
        @(posedge clk);
        rd_row <= calc_pkg::idx_t'(row);
        rd_col <= calc_pkg::idx_t'(col);
        @(posedge clk);  // registered read
        @(negedge clk);
        check_value(test, $sformatf("elem(%0d,%0d)", row, col), expected, rd_data);
    endtask

    task automatic report_bad_record(input logic [7:0] cmd);
        failures++;
        $display("calc_input.txt: malformed or unknown record '%c'", cmd);
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        int              fd;
        int              n;
        int              f0, f1, f2, f3, f4, f5, f6;
        logic [7:0]      cmd;
        logic [8*16-1:0] test;
        logic [8*128-1:0] skip;
        logic [31:0]     v0;
        mismatches = 0;
        failures   = 0;
        checks     = 0;
        sys_rst = 1'b1;
        wr_en   = 1'b0;
        dim_we  = 1'b0;
        wr_slot = '0;
        wr_row  = '0;
        wr_col  = '0;
        wr_data = '0;
        dim_m   = 3'd1;
        dim_n   = 3'd1;
        start   = 1'b0;
        op      = calc_pkg::OP_ADD;
        id_a    = '0;
        id_b    = '0;
        scalar  = '0;
        rd_row  = '0;
        rd_col  = '0;
        repeat (4) @(posedge clk);  // reset held 4 cycles
        sys_rst <= 1'b0;

        fd = $fopen("calc_input.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open calc_input.txt");
        end else begin
            // records may share a line, whitespace separates them
            while (failures == 0 && $fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": n = $fgets(skip, fd);  // comment line
                    "W": begin
                        n = $fscanf(fd, "%d %d %d %h", f0, f1, f2, v0);
                        if (n == 4) write_elem(f0, f1, f2, v0);
                        else report_bad_record(cmd);
                    end
                    "D": begin
                        n = $fscanf(fd, "%d %d %d", f0, f1, f2);
                        if (n == 3) set_dims(f0, f1, f2);
                        else report_bad_record(cmd);
                    end
                    "C": begin
                        n = $fscanf(fd, "%s %d %d %d %h %d %d %d",
                                    test, f0, f1, f2, v0, f4, f5, f6);
                        if (n == 8) run_compute(test, f0, f1, f2, v0, f4, f5, f6);
                        else report_bad_record(cmd);
                    end
                    "R": begin
                        n = $fscanf(fd, "%s %d %d %h", test, f3, f4, v0);
                        if (n == 4) read_result(test, f3, f4, v0);
                        else report_bad_record(cmd);
                    end
                    default: report_bad_record(cmd);
                endcase
            end
            $fclose(fd);
        end
        if (checks == 0) begin
            failures++;
            $display("no checks were run");
        end

        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== matrix_calc_top.sv ====
/*
 * matrix calculator top
 * connects storage, command controller and element ALU
 */
module matrix_calc_top (
    input  logic              clk,
    input  logic              sys_rst,
    input  logic              wr_en,
    input  logic              dim_we,
    input  calc_pkg::slot_t   wr_slot,
    input  calc_pkg::idx_t    wr_row,
    input  calc_pkg::idx_t    wr_col,
    input  calc_pkg::elem_t   wr_data,
    input  calc_pkg::dim_t    dim_m,
    input  calc_pkg::dim_t    dim_n,
    input  logic              start,
    input  calc_pkg::alu_op_e op,
    input  calc_pkg::slot_t   id_a,
    input  calc_pkg::slot_t   id_b,
    input  calc_pkg::elem_t   scalar,
    input  calc_pkg::idx_t    rd_row,
    input  calc_pkg::idx_t    rd_col,
    output calc_pkg::elem_t   rd_data,
    output calc_pkg::dim_t    res_m,
    output calc_pkg::dim_t    res_n,
    output logic              busy,
    output logic              done,
    output logic              error
);

    // controller side
    calc_pkg::slot_t   sel_a, sel_b;
    calc_pkg::dim_t    a_m, a_n, b_m, b_n;
    calc_pkg::dim_t    res_dim_m, res_dim_n;
    logic              res_dim_we;
    logic              alu_start, alu_done;
    calc_pkg::alu_op_e alu_op;
    calc_pkg::elem_t   alu_scalar;

    // ALU side
    calc_pkg::idx_t    a_row, a_col, b_row, b_col;
    calc_pkg::elem_t   a_data, b_data;
    logic              res_we;
    calc_pkg::idx_t    res_row, res_col;
    calc_pkg::elem_t   res_data;

    matrix_store u_store (
        .clk(clk), .sys_rst(sys_rst),
        .wr_en(wr_en), .dim_we(dim_we), .wr_slot(wr_slot),
        .wr_row(wr_row), .wr_col(wr_col), .wr_data(wr_data),
        .dim_m(dim_m), .dim_n(dim_n),
        .sel_a(sel_a), .sel_b(sel_b),
        .a_row(a_row), .a_col(a_col), .b_row(b_row), .b_col(b_col),
        .a_data(a_data), .b_data(b_data),
        .a_m(a_m), .a_n(a_n), .b_m(b_m), .b_n(b_n),
        .res_we(res_we), .res_row(res_row), .res_col(res_col), .res_data(res_data),
        .res_dim_we(res_dim_we), .res_dim_m(res_dim_m), .res_dim_n(res_dim_n),
        .rd_row(rd_row), .rd_col(rd_col), .rd_data(rd_data),
        .res_m(res_m), .res_n(res_n)
    );

    compute_ctrl u_ctrl (
        .clk(clk), .sys_rst(sys_rst),
        .start(start), .op(op), .id_a(id_a), .id_b(id_b), .scalar(scalar),
        .a_m(a_m), .a_n(a_n), .b_m(b_m), .b_n(b_n),
        .sel_a(sel_a), .sel_b(sel_b),
        .alu_start(alu_start), .alu_op(alu_op), .alu_scalar(alu_scalar),
        .alu_done(alu_done),
        .res_dim_we(res_dim_we), .res_dim_m(res_dim_m), .res_dim_n(res_dim_n),
        .busy(busy), .done(done), .error(error)
    );

    // dims come straight from the store, stable while sel is latched
    matrix_alu u_alu (
        .clk(clk), .sys_rst(sys_rst),
        .alu_start(alu_start), .alu_op(alu_op), .alu_scalar(alu_scalar),
        .a_m(a_m), .a_n(a_n), .b_n(b_n),
        .a_row(a_row), .a_col(a_col), .b_row(b_row), .b_col(b_col),
        .a_data(a_data), .b_data(b_data),
        .res_we(res_we), .res_row(res_row), .res_col(res_col), .res_data(res_data),
        .alu_done(alu_done)
    );

endmodule

// ==== matrix_alu.sv ====
/*
 * matrix ALU
 * walks the result elements in row-major order, issues K operand
 * reads per element and accumulates the returning data, with the
 * next element's reads overlapping the current write
 */
module matrix_alu (
    input  logic              clk,
    input  logic              sys_rst,
    input  logic              alu_start,
    input  calc_pkg::alu_op_e alu_op,
    input  calc_pkg::elem_t   alu_scalar,
    input  calc_pkg::dim_t    a_m,
    input  calc_pkg::dim_t    a_n,
    input  calc_pkg::dim_t    b_n,
    output calc_pkg::idx_t    a_row,
    output calc_pkg::idx_t    a_col,
    output calc_pkg::idx_t    b_row,
    output calc_pkg::idx_t    b_col,
    input  calc_pkg::elem_t   a_data,
    input  calc_pkg::elem_t   b_data,
    output logic              res_we,
    output calc_pkg::idx_t    res_row,
    output calc_pkg::idx_t    res_col,
    output calc_pkg::elem_t   res_data,
    output logic              alu_done
);

    calc_pkg::alu_state_e state;
    calc_pkg::idx_t i, j, k;                      // output row, col, inner term
    calc_pkg::idx_t rows_m1, cols_m1, k_m1;       // last index of each counter
    logic           is_tr, is_mul;

    // delay line, lines up with the registered read data
    logic           p_valid, p_first, p_last;
    calc_pkg::idx_t p_row, p_col;

    calc_pkg::elem_t term, acc, acc_next;

    assign is_tr  = (alu_op == calc_pkg::OP_TRANSPOSE);
    assign is_mul = (alu_op == calc_pkg::OP_MUL);

    // ==============================
    // counters
    // ==============================
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            state    <= calc_pkg::ALU_IDLE;
            i        <= '0;
            j        <= '0;
            k        <= '0;
            p_valid  <= 1'b0;
            alu_done <= 1'b0;
        end else begin
            p_valid  <= (state == calc_pkg::ISSUE);
            alu_done <= (state == calc_pkg::DRAIN);  // cycle after last write
            case (state)
                calc_pkg::ALU_IDLE: if (alu_start) begin
                    i     <= '0;
                    j     <= '0;
                    k     <= '0;
                    state <= calc_pkg::ISSUE;
                end
                calc_pkg::ISSUE: begin
                    if (k != k_m1) begin
                        k <= k + 3'd1;
                    end else begin
                        k <= '0;
                        if (j != cols_m1) begin
                            j <= j + 3'd1;
                        end else begin
                            j <= '0;
                            if (i != rows_m1) i <= i + 3'd1;
                            else state <= calc_pkg::DRAIN;  // last read out
                        end
                    end
                end
                default: state <= calc_pkg::ALU_IDLE;
            endcase
        end
    end

    // bounds and delay line are payload
    always_ff @(posedge clk) begin
        if (state == calc_pkg::ALU_IDLE && alu_start) begin
            rows_m1 <= (is_tr ? a_n : a_m) - 3'd1;
            cols_m1 <= (is_tr ? a_m : (is_mul ? b_n : a_n)) - 3'd1;
            k_m1    <= is_mul ? a_n - 3'd1 : 3'd0;  // K = n(A) for mul
        end
        p_first <= (k == 3'd0);
        p_last  <= (k == k_m1);
        p_row   <= i;
        p_col   <= j;
        if (p_valid) acc <= acc_next;
    end

    // ==============================
    // read addresses
    // ==============================
    assign a_row = is_tr ? j : i;
    assign a_col = is_tr ? i : (is_mul ? k : j);
    assign b_row = is_mul ? k : i;
    assign b_col = j;

    // ==============================
    // arithmetic, wraps at 32 bits
    // ==============================
    always_comb begin
        case (alu_op)
            calc_pkg::OP_ADD:    term = a_data + b_data;
            calc_pkg::OP_SUB:    term = a_data - b_data;
            calc_pkg::OP_MUL:    term = a_data * b_data;
            calc_pkg::OP_SCALAR: term = a_data * alu_scalar;
            default:             term = a_data;  // transposed copy
        endcase
    end

    assign acc_next = p_first ? term : acc + term;

    // write on the cycle the last term arrives
    assign res_we   = p_valid && p_last;
    assign res_row  = p_row;
    assign res_col  = p_col;
    assign res_data = acc_next;

    a_start_idle: assert property (@(posedge clk) disable iff (sys_rst)
        alu_start |-> state == calc_pkg::ALU_IDLE)
        else $error("alu_start while ALU active");

endmodule

// ==== compute_ctrl.sv ====
/*
 * compute controller
 * latches a request, checks operand dimensions, launches the ALU
 * and writes the result dimensions, or finishes with error
 */
module compute_ctrl (
    input  logic              clk,
    input  logic              sys_rst,
    input  logic              start,
    input  calc_pkg::alu_op_e op,
    input  calc_pkg::slot_t   id_a,
    input  calc_pkg::slot_t   id_b,
    input  calc_pkg::elem_t   scalar,
    input  calc_pkg::dim_t    a_m,
    input  calc_pkg::dim_t    a_n,
    input  calc_pkg::dim_t    b_m,
    input  calc_pkg::dim_t    b_n,
    output calc_pkg::slot_t   sel_a,
    output calc_pkg::slot_t   sel_b,
    output logic              alu_start,
    output calc_pkg::alu_op_e alu_op,
    output calc_pkg::elem_t   alu_scalar,
    input  logic              alu_done,
    output logic              res_dim_we,
    output calc_pkg::dim_t    res_dim_m,
    output calc_pkg::dim_t    res_dim_n,
    output logic              busy,
    output logic              done,
    output logic              error
);

    calc_pkg::ctrl_state_e state;
    logic dims_ok;

    // ==============================
    // dimension rules
    // ==============================
    always_comb begin
        case (alu_op)
            calc_pkg::OP_ADD,
            calc_pkg::OP_SUB: dims_ok = (a_m == b_m) && (a_n == b_n);
            calc_pkg::OP_MUL: dims_ok = (a_n == b_m);  // inner dims meet
            default:          dims_ok = 1'b1;          // transpose, scalar
        endcase
    end

    // ==============================
    // sequencer
    // ==============================
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            state     <= calc_pkg::IDLE;
            alu_start <= 1'b0;
            error     <= 1'b0;
        end else begin
            alu_start <= 1'b0;
            case (state)
                calc_pkg::IDLE: if (start) begin
                    error <= 1'b0;  // held from last op until now
                    state <= calc_pkg::CHECK;
                end
                calc_pkg::CHECK: begin
                    if (dims_ok) begin
                        alu_start <= 1'b1;
                        state     <= calc_pkg::RUN;
                    end else begin
                        error <= 1'b1;
                        state <= calc_pkg::FINISH;  // result slot untouched
                    end
                end
                calc_pkg::RUN: if (alu_done) state <= calc_pkg::FINISH;
                default: state <= calc_pkg::IDLE;
            endcase
        end
    end

    // request payload, taken only when idle
    always_ff @(posedge clk) begin
        if (state == calc_pkg::IDLE && start) begin
            alu_op     <= op;
            sel_a      <= id_a;
            sel_b      <= id_b;
            alu_scalar <= scalar;
        end
        if (state == calc_pkg::CHECK) begin
            case (alu_op)
                calc_pkg::OP_TRANSPOSE: begin
                    res_dim_m <= a_n;
                    res_dim_n <= a_m;
                end
                calc_pkg::OP_MUL: begin
                    res_dim_m <= a_m;
                    res_dim_n <= b_n;
                end
                default: begin
                    res_dim_m <= a_m;
                    res_dim_n <= a_n;
                end
            endcase
        end
    end

    assign busy       = (state != calc_pkg::IDLE);
    assign done       = (state == calc_pkg::FINISH);
    assign res_dim_we = (state == calc_pkg::FINISH) && !error;

    a_start_idle: assert property (@(posedge clk) disable iff (sys_rst)
        start |-> !busy)
        else $error("start while busy, ignored");

    a_done_pulse: assert property (@(posedge clk) disable iff (sys_rst)
        done |=> !done)
        else $error("done longer than one cycle");

    // ALU must only finish what this controller launched
    a_alu_done_run: assert property (@(posedge clk) disable iff (sys_rst)
        alu_done |-> state == calc_pkg::RUN)
        else $error("alu_done outside RUN");

endmodule

// ==== matrix_store.sv ====
/*
 * matrix storage
 * register file for all slots and their dimensions, with two operand
 * read ports, a host read port on the result slot, a host write port
 * and a result write port fixed on the result slot
 */
module matrix_store (
    input  logic            clk,
    input  logic            sys_rst,
    // host writes
    input  logic            wr_en,
    input  logic            dim_we,
    input  calc_pkg::slot_t wr_slot,
    input  calc_pkg::idx_t  wr_row,
    input  calc_pkg::idx_t  wr_col,
    input  calc_pkg::elem_t wr_data,
    input  calc_pkg::dim_t  dim_m,
    input  calc_pkg::dim_t  dim_n,
    // operand ports
    input  calc_pkg::slot_t sel_a,
    input  calc_pkg::slot_t sel_b,
    input  calc_pkg::idx_t  a_row,
    input  calc_pkg::idx_t  a_col,
    input  calc_pkg::idx_t  b_row,
    input  calc_pkg::idx_t  b_col,
    output calc_pkg::elem_t a_data,
    output calc_pkg::elem_t b_data,
    output calc_pkg::dim_t  a_m,
    output calc_pkg::dim_t  a_n,
    output calc_pkg::dim_t  b_m,
    output calc_pkg::dim_t  b_n,
    // result write
    input  logic            res_we,
    input  calc_pkg::idx_t  res_row,
    input  calc_pkg::idx_t  res_col,
    input  calc_pkg::elem_t res_data,
    input  logic            res_dim_we,
    input  calc_pkg::dim_t  res_dim_m,
    input  calc_pkg::dim_t  res_dim_n,
    // host readback
    input  calc_pkg::idx_t  rd_row,
    input  calc_pkg::idx_t  rd_col,
    output calc_pkg::elem_t rd_data,
    output calc_pkg::dim_t  res_m,
    output calc_pkg::dim_t  res_n
);

    calc_pkg::elem_t mem [calc_pkg::SLOT_COUNT][calc_pkg::MAX_DIM][calc_pkg::MAX_DIM];
    calc_pkg::dim_t  rows [calc_pkg::SLOT_COUNT];
    calc_pkg::dim_t  cols [calc_pkg::SLOT_COUNT];

    // elements and dims both come up cleared, dims as 1x1
    always_ff @(posedge clk or posedge sys_rst) begin
        if (sys_rst) begin
            for (int s = 0; s < calc_pkg::SLOT_COUNT; s++) begin
                rows[s] <= 3'd1;
                cols[s] <= 3'd1;
                for (int r = 0; r < calc_pkg::MAX_DIM; r++) begin
                    for (int c = 0; c < calc_pkg::MAX_DIM; c++) begin
                        mem[s][r][c] <= '0;
                    end
                end
            end
        end else begin
            if (wr_en) mem[wr_slot][wr_row][wr_col] <= wr_data;  // host, slots 0..2
            if (dim_we) begin
                rows[wr_slot] <= dim_m;
                cols[wr_slot] <= dim_n;
            end
            if (res_we) mem[calc_pkg::RESULT_SLOT][res_row][res_col] <= res_data;
            if (res_dim_we) begin  // end of a good op
                rows[calc_pkg::RESULT_SLOT] <= res_dim_m;
                cols[calc_pkg::RESULT_SLOT] <= res_dim_n;
            end
        end
    end

    // registered reads, one cycle latency
    always_ff @(posedge clk) begin
        a_data  <= mem[sel_a][a_row][a_col];
        b_data  <= mem[sel_b][b_row][b_col];
        rd_data <= mem[calc_pkg::RESULT_SLOT][rd_row][rd_col];
    end

    // dims are combinational
    assign a_m   = rows[sel_a];
    assign a_n   = cols[sel_a];
    assign b_m   = rows[sel_b];
    assign b_n   = cols[sel_b];
    assign res_m = rows[calc_pkg::RESULT_SLOT];
    assign res_n = cols[calc_pkg::RESULT_SLOT];

    // result slot belongs to the ALU, host keeps out
    a_host_no_result: assert property (@(posedge clk) disable iff (sys_rst)
        (wr_en || dim_we) |-> wr_slot != calc_pkg::RESULT_SLOT)
        else $error("host write aimed at result slot");

    a_dim_range: assert property (@(posedge clk) disable iff (sys_rst)
        dim_we |-> (dim_m != 0 && dim_m <= calc_pkg::MAX_DIM &&
                    dim_n != 0 && dim_n <= calc_pkg::MAX_DIM))
        else $error("dimension write out of range");

endmodule

// ==== calc_pkg.sv ====
/*
 * matrix calculator shared definitions
 * sizes, fixed slot numbers, element and index types,
 * ALU opcodes and the controller and ALU state encodings
 */
package calc_pkg;

    // ==============================
    // sizes and slots
    // ==============================
    localparam int MAX_DIM     = 5;  // largest row or column count
    localparam int SLOT_COUNT  = 4;  // three user slots plus result
    localparam int RESULT_SLOT = 3;  // every op lands here
    localparam int ELEM_W      = 32;

    // ==============================
    // data and index types
    // ==============================
    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic [2:0] idx_t;   // row or col, zero based
    typedef logic [2:0] dim_t;   // count, 1..MAX_DIM
    typedef logic [1:0] slot_t;

    // ==============================
    // encodings
    // ==============================
    typedef enum logic [2:0] {
        OP_TRANSPOSE = 3'd0,
        OP_ADD       = 3'd1,
        OP_SUB       = 3'd2,
        OP_MUL       = 3'd3,
        OP_SCALAR    = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        CHECK,   // dimension rules
        RUN,     // ALU busy
        FINISH   // done pulse
    } ctrl_state_e;

    // prefixed idle, shares the package scope with the controller states
    typedef enum logic [1:0] {
        ALU_IDLE,
        ISSUE,
        DRAIN
    } alu_state_e;

endpackage
